//--- rtl/soc_pkg.sv
// Address map, widths and bus/memory struct types shared by every block of the fabric
package soc_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  // --------------------------------------------------------------------------
  // address map
  // --------------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam int unsigned          RomLength  = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] SramBase   = 32'h8000_0000;
  localparam int unsigned          SramLength = 32'h0000_1000;

  localparam int unsigned RomWords     = RomLength / StrbWidth;
  localparam int unsigned SramWords    = SramLength / StrbWidth;
  localparam int unsigned WordIdxWidth = $clog2(SramWords);

  // debug request is held off this many cycles after reset
  localparam int unsigned DebugHoldoffCycles = 64;
  localparam int unsigned HoldoffCntWidth    = $clog2(DebugHoldoffCycles + 1);

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlverr = 2'b10,
    RespDecerr = 2'b11
  } resp_e;

  // manager side of AXI4-Lite
  typedef struct packed {
    logic                 aw_valid;
    logic [AddrWidth-1:0] aw_addr;
    logic                 w_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 b_ready;
    logic                 ar_valid;
    logic [AddrWidth-1:0] ar_addr;
    logic                 r_ready;
  } axil_req_t;

  // subordinate side of AXI4-Lite
  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic                 b_valid;
    resp_e                b_resp;
    logic                 ar_ready;
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
    resp_e                r_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [WordIdxWidth-1:0] idx;
    logic [StrbWidth-1:0]    be;
    logic [DataWidth-1:0]    wdata;
  } mem_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
  } mem_rsp_t;

endpackage

//--- rtl/axil_addr_decoder.sv
// Routes the single AXI4-Lite manager to ROM, SRAM or a local decode-error reply
`timescale 1ns/1ps

module axil_addr_decoder (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  soc_pkg::axil_req_t mgr_req_i,
  output soc_pkg::axil_rsp_t mgr_rsp_o,
  output soc_pkg::axil_req_t rom_req_o,
  input  soc_pkg::axil_rsp_t rom_rsp_i,
  output soc_pkg::axil_req_t sram_req_o,
  input  soc_pkg::axil_rsp_t sram_rsp_i
);
  import soc_pkg::*;

  typedef enum logic [1:0] {StIdle, StRom, StSram, StErr} state_e;

  state_e               state_d, state_q;
  logic                 err_write_d, err_write_q;
  logic                 wr_req, rd_req;
  logic [AddrWidth-1:0] dec_addr;
  logic                 hit_rom, hit_sram;
  logic                 sel_rom;
  axil_rsp_t            tgt_rsp;
  axil_req_t            quiet_req, fwd_req;

  function automatic logic in_region(input logic [AddrWidth-1:0] addr,
                                     input logic [AddrWidth-1:0] base,
                                     input int unsigned          length);
    return (addr >= base) && (addr < base + length);
  endfunction

  // write needs address and data together, a read waits for any pending write
  assign wr_req   = mgr_req_i.aw_valid & mgr_req_i.w_valid;
  assign rd_req   = mgr_req_i.ar_valid & ~mgr_req_i.aw_valid & ~mgr_req_i.w_valid;
  assign dec_addr = wr_req ? mgr_req_i.aw_addr : mgr_req_i.ar_addr;
  assign hit_rom  = in_region(dec_addr, RomBase, RomLength);
  assign hit_sram = in_region(dec_addr, SramBase, SramLength);

  // live decode while idle, registered target afterwards
  assign sel_rom = (state_q == StIdle) ? hit_rom : (state_q == StRom);
  assign tgt_rsp = sel_rom ? rom_rsp_i : sram_rsp_i;

  always_comb begin
    quiet_req          = mgr_req_i;
    quiet_req.aw_valid = 1'b0;
    quiet_req.w_valid  = 1'b0;
    quiet_req.ar_valid = 1'b0;
    quiet_req.b_ready  = 1'b0;
    quiet_req.r_ready  = 1'b0;

    fwd_req     = quiet_req;
    mgr_rsp_o   = '0;
    state_d     = state_q;
    err_write_d = err_write_q;

    unique case (state_q)
      StIdle: begin
        if (hit_rom || hit_sram) begin
          fwd_req.aw_valid   = wr_req;
          fwd_req.w_valid    = wr_req;
          fwd_req.ar_valid   = rd_req;
          mgr_rsp_o.aw_ready = wr_req & tgt_rsp.aw_ready;
          mgr_rsp_o.w_ready  = wr_req & tgt_rsp.w_ready;
          mgr_rsp_o.ar_ready = rd_req & tgt_rsp.ar_ready;
          if ((wr_req && tgt_rsp.aw_ready) || (rd_req && tgt_rsp.ar_ready)) begin
            state_d = hit_rom ? StRom : StSram;
          end
        end else if (wr_req || rd_req) begin
          // unmapped, take it here and answer next cycle
          mgr_rsp_o.aw_ready = wr_req;
          mgr_rsp_o.w_ready  = wr_req;
          mgr_rsp_o.ar_ready = rd_req;
          err_write_d        = wr_req;
          state_d            = StErr;
        end
      end
      StRom, StSram: begin
        fwd_req.b_ready   = mgr_req_i.b_ready;
        fwd_req.r_ready   = mgr_req_i.r_ready;
        mgr_rsp_o.b_valid = tgt_rsp.b_valid;
        mgr_rsp_o.b_resp  = tgt_rsp.b_resp;
        mgr_rsp_o.r_valid = tgt_rsp.r_valid;
        mgr_rsp_o.r_data  = tgt_rsp.r_data;
        mgr_rsp_o.r_resp  = tgt_rsp.r_resp;
        if ((tgt_rsp.b_valid && mgr_req_i.b_ready) ||
            (tgt_rsp.r_valid && mgr_req_i.r_ready)) begin
          state_d = StIdle;
        end
      end
      StErr: begin
        mgr_rsp_o.b_valid = err_write_q;
        mgr_rsp_o.b_resp  = RespDecerr;
        mgr_rsp_o.r_valid = ~err_write_q;
        mgr_rsp_o.r_resp  = RespDecerr;
        if ((err_write_q && mgr_req_i.b_ready) || (!err_write_q && mgr_req_i.r_ready)) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  assign rom_req_o  = sel_rom ? fwd_req : quiet_req;
  assign sram_req_o = sel_rom ? quiet_req : fwd_req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= StIdle;
      err_write_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      err_write_q <= err_write_d;
    end
  end

endmodule

//--- rtl/axil_mem_bridge.sv
// Turns each AXI4-Lite transaction into one single-word memory request
`timescale 1ns/1ps

module axil_mem_bridge #(
  parameter bit Writable = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  soc_pkg::axil_req_t axil_req_i,
  output soc_pkg::axil_rsp_t axil_rsp_o,
  output soc_pkg::mem_req_t  mem_req_o,
  input  soc_pkg::mem_rsp_t  mem_rsp_i
);
  import soc_pkg::*;

  typedef enum logic [1:0] {StIdle, StReq, StResp} state_e;

  state_e                  state_d, state_q;
  logic                    we_q;
  logic [WordIdxWidth-1:0] idx_q;
  logic [StrbWidth-1:0]    be_q;
  logic [DataWidth-1:0]    wdata_q;
  logic                    wr_acc, rd_acc, rsp_done;

  assign wr_acc = (state_q == StIdle) & axil_req_i.aw_valid & axil_req_i.w_valid;
  assign rd_acc = (state_q == StIdle) & axil_req_i.ar_valid & ~wr_acc;

  always_comb begin
    axil_rsp_o          = '0;
    axil_rsp_o.aw_ready = wr_acc;
    axil_rsp_o.w_ready  = wr_acc;
    axil_rsp_o.ar_ready = rd_acc;
    // write response goes out in the same cycle as the memory request
    axil_rsp_o.b_valid  = we_q & (state_q != StIdle);
    axil_rsp_o.b_resp   = Writable ? RespOkay : RespSlverr;
    // memory holds its read data until the next request
    axil_rsp_o.r_valid  = ~we_q & (state_q == StResp);
    axil_rsp_o.r_data   = mem_rsp_i.rdata;
    axil_rsp_o.r_resp   = RespOkay;
  end

  assign rsp_done = (axil_rsp_o.b_valid & axil_req_i.b_ready) |
                    (axil_rsp_o.r_valid & axil_req_i.r_ready);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle:  if (wr_acc || rd_acc) state_d = StReq;
      StReq:   state_d = rsp_done ? StIdle : StResp;
      StResp:  if (rsp_done) state_d = StIdle;
      default: state_d = StIdle;
    endcase
  end

  // read-only target never sees a write strobe
  assign mem_req_o.req   = (state_q == StReq) & (~we_q | Writable);
  assign mem_req_o.we    = we_q;
  assign mem_req_o.idx   = idx_q;
  assign mem_req_o.be    = be_q;
  assign mem_req_o.wdata = wdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_acc || rd_acc) begin
        we_q <= wr_acc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      idx_q   <= axil_req_i.aw_addr[ByteOffWidth +: WordIdxWidth];
      be_q    <= axil_req_i.w_strb;
      wdata_q <= axil_req_i.w_data;
    end else if (rd_acc) begin
      idx_q <= axil_req_i.ar_addr[ByteOffWidth +: WordIdxWidth];
    end
  end

endmodule

//--- rtl/sram_store.sv
// Word-wide SRAM model with byte-enable writes, read data registered on each request
`timescale 1ns/1ps

module sram_store (
  input  logic              clk_i,
  input  soc_pkg::mem_req_t mem_req_i,
  output soc_pkg::mem_rsp_t mem_rsp_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] mem_q [SramWords];
  logic [DataWidth-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (mem_req_i.req) begin
      if (mem_req_i.we) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          // only enabled lanes change
          if (mem_req_i.be[b]) begin
            mem_q[mem_req_i.idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
          end
        end
      end
      // old word on a write, nobody looks at it
      rdata_q <= mem_q[mem_req_i.idx];
    end
  end

  assign mem_rsp_o.rdata = rdata_q;

endmodule

//--- rtl/boot_rom.sv
// Fixed-content boot ROM table, index in the upper half and its inverse below
`timescale 1ns/1ps

module boot_rom (
  input  logic              clk_i,
  input  soc_pkg::mem_req_t mem_req_i,
  output soc_pkg::mem_rsp_t mem_rsp_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] rom_table [RomWords];
  logic [DataWidth-1:0] rdata_q;

  // ----------------------------------------------------------------------------
  // table contents
  // ----------------------------------------------------------------------------
  for (genvar k = 0; k < RomWords; k++) begin : gen_table
    assign rom_table[k] = {32'(k), ~32'(k)};
  end

  always_ff @(posedge clk_i) begin
    if (mem_req_i.req) begin
      rdata_q <= rom_table[mem_req_i.idx];
    end
  end

  assign mem_rsp_o.rdata = rdata_q;

endmodule

//--- rtl/debug_req_gate.sv
// Masks the debug request after reset for a hold-off window and while debug is off
`timescale 1ns/1ps

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);
  import soc_pkg::*;

  logic [HoldoffCntWidth-1:0] holdoff_q;

  // gives boot code time to run before a halt can land
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holdoff_q <= HoldoffCntWidth'(DebugHoldoffCycles);
    end else if (holdoff_q != '0) begin
      holdoff_q <= holdoff_q - 1'b1;
    end
  end

  // combinational once the window has closed
  assign debug_req_o = (holdoff_q == '0) & debug_en_i & debug_req_i;

endmodule

//--- rtl/soc_fabric_top.sv
// Fabric top level wiring decoder, ROM and SRAM bridges, memories and the debug gate
`timescale 1ns/1ps

module soc_fabric_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  soc_pkg::axil_req_t axil_req_i,
  output soc_pkg::axil_rsp_t axil_rsp_o,
  input  logic               debug_req_i,
  input  logic               debug_en_i,
  output logic               debug_req_o
);
  import soc_pkg::*;

  axil_req_t rom_axil_req, sram_axil_req;
  axil_rsp_t rom_axil_rsp, sram_axil_rsp;
  mem_req_t  rom_mem_req, sram_mem_req;
  mem_rsp_t  rom_mem_rsp, sram_mem_rsp;

  // ----------------------------------------------------------------------------
  // bus
  // ----------------------------------------------------------------------------
  axil_addr_decoder i_decoder (
    .clk_i      ( clk_i         ),
    .rst_ni     ( rst_ni        ),
    .mgr_req_i  ( axil_req_i    ),
    .mgr_rsp_o  ( axil_rsp_o    ),
    .rom_req_o  ( rom_axil_req  ),
    .rom_rsp_i  ( rom_axil_rsp  ),
    .sram_req_o ( sram_axil_req ),
    .sram_rsp_i ( sram_axil_rsp )
  );

  axil_mem_bridge #(
    .Writable ( 1'b0 )
  ) i_rom_bridge (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .axil_req_i ( rom_axil_req ),
    .axil_rsp_o ( rom_axil_rsp ),
    .mem_req_o  ( rom_mem_req  ),
    .mem_rsp_i  ( rom_mem_rsp  )
  );

  axil_mem_bridge #(
    .Writable ( 1'b1 )
  ) i_sram_bridge (
    .clk_i      ( clk_i         ),
    .rst_ni     ( rst_ni        ),
    .axil_req_i ( sram_axil_req ),
    .axil_rsp_o ( sram_axil_rsp ),
    .mem_req_o  ( sram_mem_req  ),
    .mem_rsp_i  ( sram_mem_rsp  )
  );

  // ----------------------------------------------------------------------------
  // memories and debug
  // ----------------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i     ( clk_i       ),
    .mem_req_i ( rom_mem_req ),
    .mem_rsp_o ( rom_mem_rsp )
  );

  sram_store i_sram (
    .clk_i     ( clk_i        ),
    .mem_req_i ( sram_mem_req ),
    .mem_rsp_o ( sram_mem_rsp )
  );

  debug_req_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- tb/soc_fabric_sva.sv
// Handshake-stability and reset assertions, bound onto the fabric top level
`timescale 1ns/1ps

module soc_fabric_sva (
  input logic               clk_i,
  input logic               rst_ni,
  input soc_pkg::axil_req_t axil_req_i,
  input soc_pkg::axil_rsp_t axil_rsp_o
);
  import soc_pkg::*;

  logic rsp_active;

  assign rsp_active = axil_rsp_o.aw_ready | axil_rsp_o.w_ready | axil_rsp_o.ar_ready |
                      axil_rsp_o.b_valid | axil_rsp_o.r_valid;

  // --------------------------------------------------------------------------
  // reset and response channel stability
  // --------------------------------------------------------------------------
  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !rsp_active)
    else $error("ready or valid output high during reset");

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_o.r_valid && !axil_req_i.r_ready |=>
      axil_rsp_o.r_valid && $stable(axil_rsp_o.r_data) && $stable(axil_rsp_o.r_resp))
    else $error("r channel changed before r_ready");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_o.b_valid && !axil_req_i.b_ready |=>
      axil_rsp_o.b_valid && $stable(axil_rsp_o.b_resp))
    else $error("b channel changed before b_ready");

endmodule

bind soc_fabric_top soc_fabric_sva i_sva (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .axil_req_i ( axil_req_i ),
  .axil_rsp_o ( axil_rsp_o )
);

//--- tb/soc_fabric_tb.sv
// Directed testbench for the fabric top level: run the simulation on soc_fabric_tb
`timescale 1ns/1ps

module soc_fabric_tb;
  import soc_pkg::*;

  localparam int ClkPeriod = 100;
  localparam int WaitLimit = 20;
  localparam int FlagAwReady = 0;
  localparam int FlagArReady = 1;
  localparam int FlagBValid  = 2;
  localparam int FlagRValid  = 3;

  logic                 clk_i;
  logic                 rst_ni;
  axil_req_t            bus_req;
  axil_rsp_t            bus_rsp;
  logic                 debug_req_i;
  logic                 debug_en_i;
  logic                 debug_req_o;
  logic [31:0]          lcg_state;
  logic [DataWidth-1:0] sram_model [SramWords];

  soc_fabric_top UUT (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .axil_req_i  ( bus_req     ),
    .axil_rsp_o  ( bus_rsp     ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] random_word();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  function automatic logic [31:0] sram_addr(input int unsigned idx);
    return SramBase + 32'(idx * StrbWidth);
  endfunction

  function automatic logic [31:0] rom_addr(input int unsigned idx);
    return RomBase + 32'(idx * StrbWidth);
  endfunction

  // reference word per the ROM rule
  function automatic logic [63:0] rom_word(input int unsigned k);
    logic [31:0] upper;
    upper = k;
    return {upper, upper ^ 32'hffff_ffff};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0]  strb);
    logic [63:0] result;
    int          b;
    result = old_word;
    for (b = 0; b < 8; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  function automatic logic rsp_flag(input int sel);
    case (sel)
      FlagAwReady: return bus_rsp.aw_ready;
      FlagArReady: return bus_rsp.ar_ready;
      FlagBValid:  return bus_rsp.b_valid;
      default:     return bus_rsp.r_valid;
    endcase
  endfunction

  // called right after a falling edge, samples mid low phase
  task automatic wait_flag(input int sel, input string what);
    int cycles;
    cycles = 0;
    #(ClkPeriod / 4);
    while (!rsp_flag(sel)) begin
      if (cycles >= WaitLimit) begin
        $display("timeout: %s did not rise within %0d cycles", what, WaitLimit);
        stop_on_failure();
      end
      cycles++;
      @(negedge clk_i);
      #(ClkPeriod / 4);
    end
  endtask

  // --------------------------------------------------------------------------
  // bus tasks
  // --------------------------------------------------------------------------
  task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, output resp_e resp);
    @(negedge clk_i);
    bus_req.aw_valid = 1'b1;
    bus_req.aw_addr  = addr;
    bus_req.w_valid  = 1'b1;
    bus_req.w_data   = data;
    bus_req.w_strb   = strb;
    wait_flag(FlagAwReady, "aw_ready");
    check_value("w_ready", 64'(bus_rsp.w_ready), 64'd1);
    @(negedge clk_i);
    bus_req.aw_valid = 1'b0;
    bus_req.w_valid  = 1'b0;
    wait_flag(FlagBValid, "b_valid");
    resp = bus_rsp.b_resp;
    // b_ready comes one cycle late, so the response has to wait
    @(negedge clk_i);
    bus_req.b_ready = 1'b1;
    #(ClkPeriod / 4);
    check_value("b_valid", 64'(bus_rsp.b_valid), 64'd1);
    check_value("b_resp", 64'(bus_rsp.b_resp), 64'(resp));
    @(negedge clk_i);
    bus_req.b_ready = 1'b0;
  endtask

  // stall holds r_ready low that many cycles once r_valid is up
  task automatic axil_read(input logic [31:0] addr, input int stall,
                           output logic [63:0] data, output resp_e resp);
    int i;
    @(negedge clk_i);
    bus_req.ar_valid = 1'b1;
    bus_req.ar_addr  = addr;
    wait_flag(FlagArReady, "ar_ready");
    @(negedge clk_i);
    bus_req.ar_valid = 1'b0;
    bus_req.r_ready  = (stall == 0);
    wait_flag(FlagRValid, "r_valid");
    data = bus_rsp.r_data;
    resp = bus_rsp.r_resp;
    for (i = 0; i < stall; i++) begin
      @(negedge clk_i);
      if (i == stall - 1) bus_req.r_ready = 1'b1;
      #(ClkPeriod / 4);
      check_value("r_valid", 64'(bus_rsp.r_valid), 64'd1);
      check_value("r_data", bus_rsp.r_data, data);
      check_value("r_resp", 64'(bus_rsp.r_resp), 64'(resp));
    end
    @(negedge clk_i);
    bus_req.r_ready = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic debug_gating();
    int cyc;
    for (cyc = 1; cyc <= 50; cyc++) begin
      @(negedge clk_i);
      check_value("debug_req_o", 64'(debug_req_o), 64'd0);
    end
    for (cyc = 51; cyc <= 80; cyc++) @(negedge clk_i);
    check_value("debug_req_o", 64'(debug_req_o), 64'd1);
    debug_en_i = 1'b0;
    #(ClkPeriod / 4);
    check_value("debug_req_o", 64'(debug_req_o), 64'd0);
  endtask

  task automatic rom_readback();
    int unsigned  idx_list [5] = '{0, 1, 5, 255, 511};
    logic [63:0]  data;
    resp_e        resp;
    foreach (idx_list[n]) begin
      axil_read(rom_addr(idx_list[n]), 0, data, resp);
      check_value("r_resp", 64'(resp), 64'(RespOkay));
      check_value("r_data", data, rom_word(idx_list[n]));
    end
  endtask

  task automatic sram_full_word();
    int unsigned idx;
    logic [63:0] wdata, data;
    resp_e       resp;
    repeat (6) begin
      idx   = lcg_next() % SramWords;
      wdata = random_word();
      axil_write(sram_addr(idx), wdata, 8'hff, resp);
      check_value("b_resp", 64'(resp), 64'(RespOkay));
      sram_model[idx] = wdata;
      axil_read(sram_addr(idx), 0, data, resp);
      check_value("r_resp", 64'(resp), 64'(RespOkay));
      check_value("r_data", data, sram_model[idx]);
    end
  endtask

  task automatic sram_byte_strobe();
    int unsigned idx;
    logic [63:0] wdata, data;
    logic [7:0]  strb;
    resp_e       resp;
    repeat (4) begin
      idx   = lcg_next() % SramWords;
      wdata = random_word();
      axil_write(sram_addr(idx), wdata, 8'hff, resp);
      sram_model[idx] = wdata;
      strb = 8'(lcg_next() >> 24);
      // keep it a true partial write
      if (strb == 8'h00 || strb == 8'hff) strb = 8'h5a;
      wdata = random_word();
      axil_write(sram_addr(idx), wdata, strb, resp);
      check_value("b_resp", 64'(resp), 64'(RespOkay));
      sram_model[idx] = merge_bytes(sram_model[idx], wdata, strb);
      axil_read(sram_addr(idx), 0, data, resp);
      check_value("r_resp", 64'(resp), 64'(RespOkay));
      check_value("r_data", data, sram_model[idx]);
    end
  endtask

  task automatic error_responses();
    logic [63:0] data;
    resp_e       resp;
    axil_write(rom_addr(3), random_word(), 8'hff, resp);
    check_value("b_resp", 64'(resp), 64'(RespSlverr));
    axil_read(rom_addr(3), 0, data, resp);
    check_value("r_resp", 64'(resp), 64'(RespOkay));
    check_value("r_data", data, rom_word(3));
    // unmapped hole and the word just past the SRAM
    axil_write(32'h4000_0000, random_word(), 8'hff, resp);
    check_value("b_resp", 64'(resp), 64'(RespDecerr));
    axil_read(32'h4000_0000, 0, data, resp);
    check_value("r_resp", 64'(resp), 64'(RespDecerr));
    check_value("r_data", data, 64'd0);
    axil_read(SramBase + SramLength, 0, data, resp);
    check_value("r_resp", 64'(resp), 64'(RespDecerr));
    check_value("r_data", data, 64'd0);
  endtask

  task automatic read_backpressure();
    int unsigned idx;
    logic [63:0] data;
    resp_e       resp;
    idx = 7;
    sram_model[idx] = random_word();
    axil_write(sram_addr(idx), sram_model[idx], 8'hff, resp);
    axil_read(sram_addr(idx), 5, data, resp);
    check_value("r_resp", 64'(resp), 64'(RespOkay));
    check_value("r_data", data, sram_model[idx]);
    axil_read(rom_addr(42), 3, data, resp);
    check_value("r_data", data, rom_word(42));
  endtask

  initial begin
    bus_req     = '0;
    rst_ni      = 1'b0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    lcg_state   = 32'hcac7c996;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    debug_gating();
    rom_readback();
    sram_full_word();
    sram_byte_strobe();
    error_responses();
    read_backpressure();

    $display("Everything OK");
    $finish;
  end

endmodule

//--- filelist.f
rtl/soc_pkg.sv
rtl/axil_addr_decoder.sv
rtl/axil_mem_bridge.sv
rtl/sram_store.sv
rtl/boot_rom.sv
rtl/debug_req_gate.sv
rtl/soc_fabric_top.sv
tb/soc_fabric_sva.sv
tb/soc_fabric_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run the fabric testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module soc_fabric_tb -o soc_fabric_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/soc_fabric_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -eq 0 ] && printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
  exit 0
else
  exit 1
fi
